// ==== fp16Pkg.sv ====
`default_nettype none

package fp16Pkg;

	// binary16 field widths
	localparam int expW  = 5;
	localparam int fracW = 10;
	localparam int manW  = fracW + 1;      // Hidden bit included
	localparam int rawW  = manW + 4;       // Carry on top, G R S below

	// Packed word, sign in bit 15
	typedef logic [15:0] fp16T;

	typedef logic [expW-1:0] expT;         // Biased exponent
	typedef logic [manW-1:0] manT;         // 1.fraction

	// Carry, 11 significand bits, guard, round, sticky
	typedef logic [rawW-1:0] rawSumT;

	localparam expT expBias = 5'd15;
	localparam expT expMax  = 5'd31;       // Reserved exponent, inf and NaN

endpackage

`default_nettype wire

// ==== fpAddCtrlPkg.sv ====
`default_nettype none

package fpAddCtrlPkg;

	// Handshake FSM
	typedef enum logic [1:0] {
		IDLE,      // Waiting for req
		BUSY,      // Token in the datapath
		DONE       // ack high, waiting for req low
	} ctrlStateT;

	// Registered stages between issue and the result
	localparam int pipeDepth = 3;

endpackage

`default_nettype wire

// ==== fpAddAlignSum.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddAlignSum
	import fp16Pkg::*;
(
	input  wire         clk,
	input  wire         rstN,
	input  wire         issue,
	input  wire fp16T   aReg,
	input  wire fp16T   bReg,
	input  wire         subReg,
	output logic        s1Valid,
	output logic        sumSign,
	output expT         bigExp,
	output rawSumT      rawSum
);

	logic        aSign, bSign;
	expT         aExp, bExp;
	manT         aMan, bMan;
	logic        swap;            // B has the larger magnitude
	logic        bigSign;
	expT         bigExpC, smlExp;
	manT         bigMan, smlMan;
	expT         expDiff;
	logic [3:0]  shAmt;
	logic [24:0] smlExt;          // Small significand with room for 14 lost bits
	logic [12:0] smlAlign;        // Significand plus guard and round
	logic        sticky;
	logic        effSub;
	rawSumT      bigOp, smlOp, sumC;

	// Unpack, subnormals read as zero
	always_comb begin
		aSign = aReg[15];
		bSign = bReg[15] ^ subReg;                        // Subtract is add of -B
		aExp  = aReg[14:10];
		bExp  = bReg[14:10];
		aMan  = (aExp == '0) ? '0 : {1'b1, aReg[9:0]};
		bMan  = (bExp == '0) ? '0 : {1'b1, bReg[9:0]};
	end

	// Magnitude order, flushed operands compare as zero
	assign swap = {bExp, bMan} > {aExp, aMan};

	assign bigSign = swap ? bSign : aSign;
	assign bigExpC = swap ? bExp : aExp;
	assign bigMan  = swap ? bMan : aMan;
	assign smlExp  = swap ? aExp : bExp;
	assign smlMan  = swap ? aMan : bMan;

	// Alignment distance, past 14 everything lands in sticky
	assign expDiff = bigExpC - smlExp;
	assign shAmt   = (expDiff > 5'd14) ? 4'd14 : expDiff[3:0];

	assign smlExt   = {smlMan, 14'b0} >> shAmt;
	assign smlAlign = smlExt[24:12];
	assign sticky   = |smlExt[11:0];                      // OR of all lost bits

	assign bigOp = {1'b0, bigMan, 3'b000};
	assign smlOp = {1'b0, smlAlign, sticky};

	// Effective operation from the two signs
	assign effSub = aSign ^ bSign;
	assign sumC   = effSub ? bigOp - smlOp : bigOp + smlOp;   // Never negative

	// Token
	always_ff @(posedge clk) begin
		if (!rstN) begin
			s1Valid <= 1'b0;
		end else begin
			s1Valid <= issue;
		end
	end

	// Stage 1 payload
	always_ff @(posedge clk) begin
		if (issue) begin
			sumSign <= bigSign;                           // Result takes sign of larger
			bigExp  <= bigExpC;
			rawSum  <= sumC;
		end
	end

endmodule

`default_nettype wire

// ==== fpNormalizeShift.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpNormalizeShift
	import fp16Pkg::*;
(
	input  wire                clk,
	input  wire                rstN,
	input  wire                s1Valid,
	input  wire                sumSign,
	input  wire expT           bigExp,
	input  wire rawSumT        rawSum,
	output logic               s2Valid,
	output logic               normSign,
	output logic signed [5:0]  normExp,
	output rawSumT             normSig,
	output logic               isZero
);

	logic [13:0]       body;       // Sum below the carry bit
	logic [3:0]        lz;         // Leading zeros of body
	logic [13:0]       lvl1, lvl2;
	rawSumT            sigC;
	logic signed [5:0] expC;

	assign body = rawSum[13:0];

	// Priority count, highest set bit wins
	always_comb begin
		lz = 4'd14;                                   // All zero
		for (int i = 0; i < 14; i++) begin
			if (body[i]) lz = 4'(13 - i);
		end
	end

	always_comb begin                                 // Coarse shift 0/4/8/12
		case (lz[3:2])
			2'b00:   lvl1 = body;
			2'b01:   lvl1 = {body[9:0], 4'b0};
			2'b10:   lvl1 = {body[5:0], 8'b0};
			default: lvl1 = {body[1:0], 12'b0};
		endcase
	end

	always_comb begin                                 // Fine shift 0/1/2/3
		case (lz[1:0])
			2'b00:   lvl2 = lvl1;
			2'b01:   lvl2 = {lvl1[12:0], 1'b0};
			2'b10:   lvl2 = {lvl1[11:0], 2'b0};
			default: lvl2 = {lvl1[10:0], 3'b0};
		endcase
	end

	// Carry out moves right one, else left by lz
	always_comb begin
		if (rawSum[14]) begin
			sigC = {1'b0, rawSum[14:2], rawSum[1] | rawSum[0]};   // Keep sticky
			expC = $signed({1'b0, bigExp}) + 6'sd1;
		end else begin
			sigC = {1'b0, lvl2};
			expC = $signed({1'b0, bigExp}) - $signed({2'b0, lz});
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			s2Valid <= 1'b0;
		end else begin
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1Valid) begin
			normSign <= sumSign;
			normExp  <= expC;
			normSig  <= sigC;
			isZero   <= (rawSum == '0);               // Exact cancellation
		end
	end

endmodule

`default_nettype wire

// ==== fpRoundPack.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpRoundPack
	import fp16Pkg::*;
(
	input  wire                clk,
	input  wire                rstN,
	input  wire                s2Valid,
	input  wire                normSign,
	input  wire signed [5:0]   normExp,
	input  wire rawSumT        normSig,
	input  wire                isZero,
	output logic               s3Valid,
	output fp16T               resOut,
	output logic               ovfOut,
	output logic               inxOut
);

	manT               man;        // 1.fraction before rounding
	logic              guard, rnd, stk;
	logic              roundUp;
	logic              lost;       // Any bit dropped
	logic [11:0]       manRnd;     // One spare bit for mantissa overflow
	logic [9:0]        frac;
	logic signed [6:0] expRnd;
	fp16T              resC;
	logic              ovfC, inxC;

	assign man   = normSig[13:3];
	assign guard = normSig[2];
	assign rnd   = normSig[1];
	assign stk   = normSig[0];

	// Nearest even, ties go to even LSB
	assign roundUp = guard & (rnd | stk | man[0]);
	assign lost    = guard | rnd | stk;

	assign manRnd = {1'b0, man} + {11'b0, roundUp};

	// 1.111..1 + 1 wraps to 10.000..0
	assign frac   = manRnd[11] ? manRnd[10:1] : manRnd[9:0];
	assign expRnd = {normExp[5], normExp} + {6'b0, manRnd[11]};

	always_comb begin
		ovfC = 1'b0;
		inxC = lost;
		resC = {normSign, expRnd[4:0], frac};
		if (isZero) begin
			resC = '0;                                    // Cancellation gives +0
			inxC = 1'b0;
		end else if (expRnd >= $signed({2'b0, expMax})) begin
			resC = {normSign, expMax, 10'b0};             // Signed infinity
			ovfC = 1'b1;
			inxC = 1'b1;
		end else if (expRnd <= 7'sd0) begin
			resC = {normSign, 15'b0};                     // Flush to signed zero
			inxC = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			s3Valid <= 1'b0;
		end else begin
			s3Valid <= s2Valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s2Valid) begin
			resOut <= resC;
			ovfOut <= ovfC;
			inxOut <= inxC;
		end
	end

endmodule

`default_nettype wire

// ==== fpAddCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddCtrl
	import fpAddCtrlPkg::*;
	import fp16Pkg::*;
(
	input  wire         clk,
	input  wire         rstN,
	input  wire         req,
	input  wire fp16T   opA,
	input  wire fp16T   opB,
	input  wire         sub,
	output logic        ack,
	output logic        issue,
	output fp16T        aReg,
	output fp16T        bReg,
	output logic        subReg,
	input  wire         s3Valid,
	input  wire fp16T   resIn,
	input  wire         ovfIn,
	input  wire         inxIn,
	output fp16T        result,
	output logic        overflow,
	output logic        inexact
);

	localparam int cntW = $clog2(pipeDepth + 1);

	ctrlStateT       state;
	logic [cntW-1:0] flight;      // Stages the token has yet to cross
	logic            take;        // Accept a new operand pair
	logic            capture;     // Result reached the last stage

	assign take    = (state == IDLE) && req;
	assign capture = (state == BUSY) && s3Valid && (flight == '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state  <= IDLE;
			ack    <= 1'b0;
			issue  <= 1'b0;
			flight <= '0;
		end else begin
			issue <= 1'b0;                                // One-cycle pulse
			if (flight != '0) flight <= flight - 1'b1;
			case (state)
				IDLE: if (take) begin
					issue  <= 1'b1;
					flight <= cntW'(pipeDepth);
					state  <= BUSY;
				end
				BUSY: if (capture) begin
					ack   <= 1'b1;
					state <= DONE;
				end
				DONE: if (!req) begin                     // Four-phase return
					ack   <= 1'b0;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Operands held for the datapath, result held while ack is high
	always_ff @(posedge clk) begin
		if (take) begin
			aReg   <= opA;
			bReg   <= opB;
			subReg <= sub;
		end
		if (capture) begin
			result   <= resIn;
			overflow <= ovfIn;
			inexact  <= inxIn;
		end
	end

endmodule

`default_nettype wire

// ==== fpAddSub.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddSub
	import fp16Pkg::*;
(
	input  wire         clk,
	input  wire         rstN,
	input  wire         req,
	input  wire fp16T   opA,
	input  wire fp16T   opB,
	input  wire         sub,
	output logic        ack,
	output fp16T        result,
	output logic        overflow,
	output logic        inexact
);

	logic              issue;
	fp16T              aReg, bReg;
	logic              subReg;
	logic              s1Valid, s2Valid, s3Valid;   // Token chain
	logic              sumSign;
	expT               bigExp;
	rawSumT            rawSum;
	logic              normSign;
	logic signed [5:0] normExp;
	rawSumT            normSig;
	logic              isZero;
	fp16T              resOut;
	logic              ovfOut, inxOut;

	fpAddCtrl uCtrl (
		.clk      (clk),
		.rstN     (rstN),
		.req      (req),
		.opA      (opA),
		.opB      (opB),
		.sub      (sub),
		.ack      (ack),
		.issue    (issue),
		.aReg     (aReg),
		.bReg     (bReg),
		.subReg   (subReg),
		.s3Valid  (s3Valid),
		.resIn    (resOut),
		.ovfIn    (ovfOut),
		.inxIn    (inxOut),
		.result   (result),
		.overflow (overflow),
		.inexact  (inexact)
	);

	fpAddAlignSum uAlign (                           // Stage 1
		.clk     (clk),
		.rstN    (rstN),
		.issue   (issue),
		.aReg    (aReg),
		.bReg    (bReg),
		.subReg  (subReg),
		.s1Valid (s1Valid),
		.sumSign (sumSign),
		.bigExp  (bigExp),
		.rawSum  (rawSum)
	);

	fpNormalizeShift uNorm (                         // Stage 2
		.clk      (clk),
		.rstN     (rstN),
		.s1Valid  (s1Valid),
		.sumSign  (sumSign),
		.bigExp   (bigExp),
		.rawSum   (rawSum),
		.s2Valid  (s2Valid),
		.normSign (normSign),
		.normExp  (normExp),
		.normSig  (normSig),
		.isZero   (isZero)
	);

	fpRoundPack uRound (                             // Stage 3
		.clk      (clk),
		.rstN     (rstN),
		.s2Valid  (s2Valid),
		.normSign (normSign),
		.normExp  (normExp),
		.normSig  (normSig),
		.isZero   (isZero),
		.s3Valid  (s3Valid),
		.resOut   (resOut),
		.ovfOut   (ovfOut),
		.inxOut   (inxOut)
	);

endmodule

`default_nettype wire

// ==== fpAddSubHandshake_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpAddSubHandshakeSva
	import fpAddCtrlPkg::*;
	import fp16Pkg::*;
(
	input wire       clk,
	input wire       rstN,
	input wire       req,
	input wire       ack,
	input wire fp16T result,
	input wire       overflow,
	input wire       inexact
);

	// ack register set pipeDepth+1 edges after req is sampled, seen one sample later
	ackAfterReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(ack) |-> $past(req, pipeDepth + 2) && !$past(req, pipeDepth + 3))
		else $error("ack rose at the wrong distance from the req rise");

	ackUntilReqFall: assert property (@(posedge clk) disable iff (!rstN)
		ack && req |=> ack)
		else $error("ack dropped while req was still high");

	resultHeld: assert property (@(posedge clk) disable iff (!rstN)
		ack && $past(ack) |-> $stable({result, overflow, inexact}))
		else $error("result or flags changed while ack was high");

	ackLowInReset: assert property (@(posedge clk) !rstN |=> !ack)
		else $error("ack high after a reset cycle");

endmodule

bind fpAddSub fpAddSubHandshakeSva uHandshakeSva (
	.clk      (clk),
	.rstN     (rstN),
	.req      (req),
	.ack      (ack),
	.result   (result),
	.overflow (overflow),
	.inexact  (inexact)
);

`default_nettype wire

// ==== tbFpAddSub.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbFpAddSub
	import fp16Pkg::*;
();

	localparam int          clkPeriod   = 40;
	localparam int          resetCycles = 5;
	localparam int          driveDelay  = 2;        // Inputs change this long after the edge
	localparam int          numTrans    = 400;
	localparam int          maxWait     = 20;       // Cycles allowed for ack
	localparam int          ackLatency  = 4;        // Edges from req sample to ack set
	localparam int          watchdogNs  = numTrans * 20 * clkPeriod;
	localparam int unsigned rngSeed     = 32'h4dd7cbab;

	logic        clk;
	logic        rstN;
	logic        req;
	fp16T        opA, opB;
	logic        sub;
	logic        ack;
	fp16T        result;
	logic        overflow, inexact;

	int          errors;
	int          checks;

	fpAddSub u_dut (
		.clk      (clk),
		.rstN     (rstN),
		.req      (req),
		.opA      (opA),
		.opB      (opB),
		.sub      (sub),
		.ack      (ack),
		.result   (result),
		.overflow (overflow),
		.inexact  (inexact)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Sample point and drive point in one
	task automatic nextCycle();
		@(posedge clk);
		#(driveDelay);
	endtask

	task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] want);
		checks++;
		assert (got === want) else begin
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	// Exact value in units of 2^-24, subnormals read as zero
	function automatic longint toScaled(input fp16T x, input logic flip);
		longint mag;
		if (x[14:10] == 5'd0) mag = 0;
		else mag = longint'({1'b1, x[9:0]}) << (x[14:10] - 1);
		return (x[15] ^ flip) ? -mag : mag;
	endfunction

	// Exact sum, then round to 11 significant bits, nearest even
	task automatic refModel(input fp16T a, input fp16T b, input logic s,
			output fp16T r, output logic ovf, output logic inx);
		longint sum, mag, kept, rem, half;
		int     msb, sh, bexp;
		logic   neg, up;
		sum = toScaled(a, 1'b0) + toScaled(b, s);
		neg = (sum < 0);
		mag = neg ? -sum : sum;
		msb = 0;
		for (int i = 0; i < 48; i++) begin
			if (mag[i]) msb = i;
		end
		bexp = msb - 9;                               // 2^(msb-24), bias 15
		up   = 1'b0;
		inx  = 1'b0;
		ovf  = 1'b0;
		if (msb > 10) begin
			sh   = msb - 10;
			kept = mag >> sh;
			rem  = mag & ((longint'(1) << sh) - 1);   // Bits below the LSB
			half = longint'(1) << (sh - 1);
			up   = (rem > half) || ((rem == half) && kept[0]);
			inx  = (rem != 0);
		end else begin
			kept = mag << (10 - msb);                 // Short result, no loss
		end
		if (up) kept = kept + 1;
		if (kept == 2048) begin                       // Rounded into the next binade
			kept = 1024;
			bexp = bexp + 1;
		end
		if (sum == 0) begin
			r   = '0;                                 // Cancellation is +0
			inx = 1'b0;
		end else if (bexp >= 31) begin
			r   = {neg, 5'd31, 10'd0};
			ovf = 1'b1;
			inx = 1'b1;
		end else if (bexp <= 0) begin
			r   = {neg, 15'd0};                       // Flush, signed
			inx = 1'b1;
		end else begin
			r = {neg, bexp[4:0], kept[9:0]};
		end
	endtask

	function automatic fp16T randNormal(input int lo, input int hi);
		int e;
		e = lo + int'($urandom % (hi - lo + 1));
		return {1'($urandom), 5'(e), 10'($urandom)};
	endfunction

	// Operand pair from one of several corner classes
	task automatic pickPair(output fp16T a, output fp16T b, output logic s);
		int   kind;
		int   e;
		fp16T t;
		kind = int'($urandom % 8);
		a = randNormal(1, 30);
		b = randNormal(1, 30);
		s = 1'($urandom);
		case (kind)
			3: begin                                  // Near exponents, deep cancellation
				b[14:10] = a[14:10];
				if ($urandom % 2 == 0 && a[14:10] > 5'd1) b[14:10] = a[14:10] - 5'd1;
			end
			4: begin                                  // Equal magnitude, opposite effective sign
				if ($urandom % 2 == 0) begin
					b = a;
					s = 1'b1;
				end else begin
					b = {~a[15], a[14:0]};
					s = 1'b0;
				end
			end
			5: begin                                  // Top of the range
				a = randNormal(29, 30);
				b = randNormal(29, 30);
				b[15] = a[15] ^ s;
			end
			6: begin
				if ($urandom % 2 == 0) begin          // One ULP apart at the bottom
					a = randNormal(1, 2);
					b = {a[15:1], ~a[0]};
					s = 1'b1;
				end else begin                        // Subnormal or zero
					b = {1'($urandom), 5'd0, 10'($urandom)};
					if ($urandom % 4 == 0) b[9:0] = 10'd0;
				end
			end
			7: begin                                  // B is exactly half an ULP of A
				e = 12 + int'($urandom % 19);
				a = {1'($urandom), 5'(e), 10'($urandom)};
				b = {a[15] ^ 1'($urandom), 5'(e - 11), 10'd0};
				s = 1'b0;
			end
			default: ;                                // Plain random normals
		endcase
		if ($urandom % 2 == 0) begin
			t = a;
			a = b;
			b = t;
		end
	endtask

	task automatic runTransaction(input int idx);
		fp16T  a, b, wantRes, heldRes;
		logic  s, wantOvf, wantInx;
		int    gap, waited;
		string tag;
		pickPair(a, b, s);
		refModel(a, b, s, wantRes, wantOvf, wantInx);
		tag = $sformatf("#%0d %h %s %h", idx, a, s ? "-" : "+", b);
		gap = int'($urandom % 6);
		repeat (gap) nextCycle();
		opA = a;
		opB = b;
		sub = s;
		req = 1'b1;
		nextCycle();                                  // Edge that samples req
		waited = 0;
		while (!ack && waited < maxWait) begin
			nextCycle();
			waited++;
		end
		assert (ack) else begin
			$display("Transaction %s got no ack within %0d cycles", tag, maxWait);
			errors++;
		end
		if (ack) begin
			checkVal({"ack latency ", tag}, 16'(waited), 16'(ackLatency));
			checkVal({"result ", tag}, result, wantRes);
			checkVal({"overflow ", tag}, 16'(overflow), 16'(wantOvf));
			checkVal({"inexact ", tag}, 16'(inexact), 16'(wantInx));
			heldRes = result;
			gap = int'($urandom % 6);                 // Slow req fall
			repeat (gap) begin
				nextCycle();
				checkVal("ack held", 16'(ack), 16'd1);
				checkVal("result held", result, heldRes);
			end
		end
		req = 1'b0;
		nextCycle();
		checkVal("ack after req fall", 16'(ack), 16'd0);
	endtask

	initial begin
		void'($urandom(rngSeed));
		errors   = 0;
		checks   = 0;
		rstN     = 1'b0;
		req      = 1'b0;
		opA      = '0;
		opB      = '0;
		sub      = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		rstN = 1'b1;
		checkVal("ack after reset", 16'(ack), 16'd0);
		for (int i = 0; i < numTrans; i++) begin
			runTransaction(i);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Hang guard
	initial begin
		#(watchdogNs);
		$display("Timeout after %0d ns, the test loop did not finish", watchdogNs);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
fp16Pkg.sv
fpAddCtrlPkg.sv
fpAddAlignSum.sv
fpNormalizeShift.sv
fpRoundPack.sv
fpAddCtrl.sv
fpAddSub.sv
fpAddSubHandshake_sva.sv
tbFpAddSub.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fpAddSub testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simName=simFpAddSub
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbFpAddSub -f verilog.f --Mdir "$buildDir" -o "$simName"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/$simName" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "ERRORS FOUND" "$logFile"; then
	echo "Simulation failed"
	exit 1
fi

if ! grep -q "NO ERRORS" "$logFile"; then
	echo "Simulation ended without a result line"
	exit 1
fi

echo "Simulation passed"
exit 0
